/* fsq.f */
+incdir+logic
logic/fsqPkg.sv
logic/fsqEnqueue.sv
logic/fsqStreamRam.sv
logic/fsqCacheIssue.sv
logic/fsqCommit.sv
logic/fsqTop.sv
sim/fsqTb.sv

/* logic/fsqCacheIssue.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqCacheIssue (
    input  logic clk,
    input  logic rst,
    input  fsqPkg::fsqPtrT tail,
    input  logic cacheReady,
    input  fsqPkg::redirectT redirect,
    input  fsqPkg::fetchStreamT searchStream,
    output fsqPkg::fsqIdxT searchIdx,
    output fsqPkg::cacheReqT cacheReq
);

    fsqPkg::fsqPtrT searchHead;
    fsqPkg::fsqPtrT redirPtr;
    fsqPkg::fsqPtrT redirNext;
    logic [`FSQ_WIDTH:0] unissued;
    logic issue;
    logic reqValid;
    fsqPkg::fsqIdxT reqIdx;
    fsqPkg::fetchStreamT reqStream;

    assign issue = (searchHead != tail) & cacheReady & ~redirect.en;
    assign searchIdx = searchHead.idx;

    // redirected entry lies behind tail, so its lap follows from tail
    always_comb begin
        redirPtr.idx = redirect.idx;
        redirPtr.dir = (redirect.idx < tail.idx) ? tail.dir : ~tail.dir;
        redirNext = fsqPkg::fsqPtrT'(redirPtr + 1'b1);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            searchHead <= '0;
        end else if (redirect.en) begin
            searchHead <= redirNext;
        end else if (issue) begin
            searchHead <= fsqPkg::fsqPtrT'(searchHead + 1'b1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            reqIdx <= searchHead.idx;
            reqStream <= searchStream;
        end
    end

    assign cacheReq.valid = reqValid;
    assign cacheReq.idx = reqIdx;
    assign cacheReq.stream = reqStream;

    // streams between search head and tail, never more than the depth
    assign unissued = tail - searchHead;

    assert property (@(posedge clk) disable iff (rst)
        unissued <= `FSQ_SIZE)
        else $error("search head passed the tail");

endmodule

/* logic/fsqCommit.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqCommit (
    input  logic clk,
    input  logic rst,
    input  logic [`COMMIT_WIDTH-1:0] commitCnt,
    input  fsqPkg::fetchStreamT commitStream,
    output fsqPkg::fsqPtrT commitHead,
    output fsqPkg::updateT update
);

    logic [`COMMIT_WIDTH:0] pending;
    logic [`COMMIT_WIDTH:0] streamLen;
    logic retire;
    logic updValid;
    fsqPkg::fsqIdxT updIdx;
    fsqPkg::addrT updAddr;
    fsqPkg::offsetT updSize;

    // instructions in the head stream
    assign streamLen = (`COMMIT_WIDTH+1)'(commitStream.size) + 1'b1;

    // head is done once every instruction up to size is committed
    assign retire = pending > (`COMMIT_WIDTH+1)'(commitStream.size);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending + (`COMMIT_WIDTH+1)'(commitCnt) - (retire ? streamLen : '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitHead <= '0;
        end else if (retire) begin
            commitHead <= fsqPkg::fsqPtrT'(commitHead + 1'b1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            updValid <= 1'b0;
        end else begin
            updValid <= retire;
        end
    end

    // predictor update carries the retired stream
    always_ff @(posedge clk) begin
        if (retire) begin
            updIdx <= commitHead.idx;
            updAddr <= commitStream.startAddr;
            updSize <= commitStream.size;
        end
    end

    assign update.valid = updValid;
    assign update.idx = updIdx;
    assign update.startAddr = updAddr;
    assign update.size = updSize;

    // backend never runs far ahead of the retiring streams
    assert property (@(posedge clk) disable iff (rst)
        pending <= 12)
        else $error("pending commit count exceeded 12");

endmodule

/* logic/fsqEnqueue.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqEnqueue (
    input  logic clk,
    input  logic rst,
    input  logic predEn,
    input  fsqPkg::redirectT redirect,
    input  fsqPkg::fsqPtrT commitHead,
    output fsqPkg::fsqPtrT tail,
    output logic predStall,
    output logic wrEn,
    output fsqPkg::squashT squash
);

    fsqPkg::fsqPtrT redirPtr;
    fsqPkg::fsqPtrT redirNext;
    logic full;
    logic squashEn;
    fsqPkg::addrT squashTarget;
    logic [`FSQ_WIDTH:0] occupancy;

    // same index on different laps
    assign full = (tail.idx == commitHead.idx) && (tail.dir != commitHead.dir);
    assign predStall = full;

    // no enqueue while the backend redirects
    assign wrEn = predEn & ~full & ~redirect.en;

    // lap of the redirected entry, seen from the commit head
    always_comb begin
        redirPtr.idx = redirect.idx;
        redirPtr.dir = (redirect.idx >= commitHead.idx) ? commitHead.dir : ~commitHead.dir;
        redirNext = fsqPkg::fsqPtrT'(redirPtr + 1'b1);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else if (redirect.en) begin
            // younger streams are dropped
            tail <= redirNext;
        end else if (wrEn) begin
            tail <= fsqPkg::fsqPtrT'(tail + 1'b1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squashEn <= 1'b0;
        end else begin
            squashEn <= redirect.en;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.en) begin
            squashTarget <= redirect.target;
        end
    end

    assign squash.en = squashEn;
    assign squash.target = squashTarget;

    // streams between commit head and tail
    assign occupancy = tail - commitHead;

    // commit head never passes the tail
    assert property (@(posedge clk) disable iff (rst)
        occupancy <= `FSQ_SIZE)
        else $error("queue occupancy exceeded its depth");

endmodule

/* logic/fsqPkg.sv */
`include "fsq_cfg.svh"

package fsqPkg;

    typedef logic [`FSQ_WIDTH-1:0] fsqIdxT;
    typedef logic [`VADDR_SIZE-1:0] addrT;
    typedef logic [`PREDICTION_WIDTH-1:0] offsetT;

    // dir flips every time idx wraps around
    typedef struct packed {
        logic dir;
        fsqIdxT idx;
    } fsqPtrT;

    // size is the offset of the last instruction
    typedef struct packed {
        addrT startAddr;
        offsetT size;
        addrT target;
    } fetchStreamT;

    typedef struct packed {
        logic en;
        fsqIdxT idx;
        offsetT offset;
        addrT target;
    } redirectT;

    typedef struct packed {
        logic valid;
        fsqIdxT idx;
        fetchStreamT stream;
    } cacheReqT;

    typedef struct packed {
        logic valid;
        fsqIdxT idx;
        addrT startAddr;
        offsetT size;
    } updateT;

    typedef struct packed {
        logic en;
        addrT target;
    } squashT;

endpackage

/* logic/fsqStreamRam.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqStreamRam (
    input  logic clk,
    input  logic rst,
    input  logic wrEn,
    input  fsqPkg::fsqIdxT wrIdx,
    input  fsqPkg::fetchStreamT wrStream,
    input  fsqPkg::redirectT redirect,
    input  fsqPkg::fsqIdxT searchIdx,
    input  fsqPkg::fsqIdxT commitIdx,
    output fsqPkg::fetchStreamT searchStream,
    output fsqPkg::fetchStreamT commitStream
);

    fsqPkg::fetchStreamT mem [0:`FSQ_SIZE-1];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIdx] <= wrStream;
        end
        // resolved branch fixes the block end and target
        if (redirect.en) begin
            mem[redirect.idx].size <= redirect.offset;
            mem[redirect.idx].target <= redirect.target;
        end
    end

    // search port feeds the cache, commit port feeds retirement
    assign searchStream = mem[searchIdx];
    assign commitStream = mem[commitIdx];

    // enqueue is held off during a redirect, so the two writes never meet
    assert property (@(posedge clk) disable iff (rst)
        !(wrEn && redirect.en))
        else $error("enqueue write collided with a redirect patch");

endmodule

/* logic/fsqTop.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqTop (
    input  logic clk,
    input  logic rst,
    input  logic predEn,
    input  fsqPkg::fetchStreamT predStream,
    output logic predStall,
    input  logic cacheReady,
    output fsqPkg::cacheReqT cacheReq,
    input  fsqPkg::redirectT redirect,
    input  logic [`COMMIT_WIDTH-1:0] commitCnt,
    output fsqPkg::squashT squash,
    output fsqPkg::updateT update
);

    fsqPkg::fsqPtrT tail;
    fsqPkg::fsqPtrT commitHead;
    logic wrEn;
    fsqPkg::fsqIdxT searchIdx;
    fsqPkg::fetchStreamT searchStream;
    fsqPkg::fetchStreamT commitStream;

    fsqEnqueue enq0 (
        .clk(clk),
        .rst(rst),
        .predEn(predEn),
        .redirect(redirect),
        .commitHead(commitHead),
        .tail(tail),
        .predStall(predStall),
        .wrEn(wrEn),
        .squash(squash)
    );

    fsqStreamRam ram0 (
        .clk(clk),
        .rst(rst),
        .wrEn(wrEn),
        .wrIdx(tail.idx),
        .wrStream(predStream),
        .redirect(redirect),
        .searchIdx(searchIdx),
        .commitIdx(commitHead.idx),
        .searchStream(searchStream),
        .commitStream(commitStream)
    );

    fsqCacheIssue issue0 (
        .clk(clk),
        .rst(rst),
        .tail(tail),
        .cacheReady(cacheReady),
        .redirect(redirect),
        .searchStream(searchStream),
        .searchIdx(searchIdx),
        .cacheReq(cacheReq)
    );

    fsqCommit commit0 (
        .clk(clk),
        .rst(rst),
        .commitCnt(commitCnt),
        .commitStream(commitStream),
        .commitHead(commitHead),
        .update(update)
    );

endmodule

/* logic/fsq_cfg.svh */
`ifndef FSQ_CFG_SVH
`define FSQ_CFG_SVH

// queue index bits, 8 entries
`define FSQ_WIDTH 3
`define FSQ_SIZE (1 << `FSQ_WIDTH)

// virtual address width
`define VADDR_SIZE 32

// offset of an instruction inside a fetch block
`define PREDICTION_WIDTH 3

// committed instructions per cycle, 0 to 4
`define COMMIT_WIDTH 3

`endif

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module fsqTb -f fsq.f -o fsqSim &&
    ./obj_dir/fsqSim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
    echo "fsq run passed" ||
    { echo "fsq run failed"; exit 1; }

/* sim/fsqTb.sv */
`timescale 1ns/1ns
`include "fsq_cfg.svh"

module fsqTb;

    localparam int MaxCycles = 4000;
    localparam int StreamCount = 300;

    logic clk;
    logic rst;
    logic predEn = 1'b0;
    fsqPkg::fetchStreamT predStream = '0;
    logic predStall;
    logic cacheReady = 1'b0;
    fsqPkg::cacheReqT cacheReq;
    fsqPkg::redirectT redirect = '0;
    logic [`COMMIT_WIDTH-1:0] commitCnt = '0;
    fsqPkg::squashT squash;
    fsqPkg::updateT update;

    // model pointers count streams and never wrap
    fsqPkg::fetchStreamT modelMem [0:`FSQ_SIZE-1];
    int tailCnt = 0;
    int srchCnt = 0;
    int headCnt = 0;
    int pending = 0;
    int accepted = 0;
    int cycles = 0;
    int mode = 0;
    int readyLeft = 0;
    logic readyLevel = 1'b0;
    fsqPkg::cacheReqT expReq = '0;
    fsqPkg::updateT expUpd = '0;
    fsqPkg::redirectT lastRedirect = '0;

    fsqTop dut0 (
        .clk(clk),
        .rst(rst),
        .predEn(predEn),
        .predStream(predStream),
        .predStall(predStall),
        .cacheReady(cacheReady),
        .cacheReq(cacheReq),
        .redirect(redirect),
        .commitCnt(commitCnt),
        .squash(squash),
        .update(update)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int slot(int cnt);
        return cnt % `FSQ_SIZE;
    endfunction

    // instructions held from the head up to position last
    function automatic int instrUpTo(int last);
        int sum;
        sum = 0;
        for (int p = headCnt; p < last; p++) begin
            sum += int'(modelMem[slot(p)].size) + 1;
        end
        return sum;
    endfunction

    // head retires once more than size instructions are committed
    function automatic int retireLen();
        int size;
        size = int'(modelMem[slot(headCnt)].size);
        return (pending > size) ? size + 1 : 0;
    endfunction

    function automatic fsqPkg::cacheReqT nextCacheReq(logic issue);
        return {issue, fsqPkg::fsqIdxT'(slot(srchCnt)), modelMem[slot(srchCnt)]};
    endfunction

    function automatic fsqPkg::updateT nextUpdate(logic retire);
        fsqPkg::fetchStreamT s;
        s = modelMem[slot(headCnt)];
        return {retire, fsqPkg::fsqIdxT'(slot(headCnt)), s.startAddr, s.size};
    endfunction

    function automatic fsqPkg::fetchStreamT randomStream();
        fsqPkg::fetchStreamT s;
        s.startAddr = $urandom;
        s.size = fsqPkg::offsetT'($urandom % 8);
        s.target = $urandom;
        return s;
    endfunction

    task automatic stopRun();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(string name, logic [127:0] got, logic [127:0] exp);
        assert (got === exp)
            else begin
                $display("[ERROR] %s got %h expected %h", name, got, exp);
                stopRun();
            end
    endtask

    // inputs read here are the ones the DUT samples at this edge
    always @(posedge clk) begin : modelStep
        logic accept;
        logic issue;
        int len;
        int pos;
        int cnt;
        fsqPkg::redirectT redir;
        if (!rst) begin
            cycles++;
            if (cycles >= MaxCycles) begin
                $display("run timed out after %0d cycles, %0d streams in", cycles, accepted);
                stopRun();
            end
            accept = predEn && (tailCnt - headCnt < `FSQ_SIZE) && !redirect.en;
            issue = (srchCnt != tailCnt) && cacheReady && !redirect.en;
            len = retireLen();
            expReq = nextCacheReq(issue);
            expUpd = nextUpdate(len > 0);
            lastRedirect = redirect;
            if (redirect.en) begin
                // position of the entry on the lap that starts at the head
                pos = headCnt + (int'(redirect.idx) - slot(headCnt) + `FSQ_SIZE) % `FSQ_SIZE;
                modelMem[redirect.idx].size = redirect.offset;
                modelMem[redirect.idx].target = redirect.target;
                tailCnt = pos + 1;
                srchCnt = pos + 1;
            end else begin
                if (accept) begin
                    modelMem[slot(tailCnt)] = predStream;
                    tailCnt++;
                    accepted++;
                end
                if (issue) begin
                    srchCnt++;
                end
            end
            pending = pending + int'(commitCnt) - len;
            if (len > 0) begin
                headCnt++;
            end

            if (readyLeft == 0) begin
                readyLeft = 1 + $urandom % 12;
                readyLevel = ($urandom % 3) != 0;
            end
            readyLeft--;
            redir = '0;
            cnt = $urandom % 5;
            // redirect only the youngest issued entry, none of it committed yet
            if (mode == 2 && srchCnt - 1 > headCnt && pending <= instrUpTo(srchCnt - 1)
                    && $urandom % 30 == 0) begin
                redir.en = 1'b1;
                redir.idx = fsqPkg::fsqIdxT'(slot(srchCnt - 1));
                redir.offset = fsqPkg::offsetT'($urandom % 8);
                redir.target = $urandom;
                cnt = 0;
            end
            // backend commits issued instructions only
            if (cnt > instrUpTo(srchCnt) - pending) begin
                cnt = instrUpTo(srchCnt) - pending;
            end
            if (cnt > 8 - pending + retireLen()) begin
                cnt = 8 - pending + retireLen();
            end
            predEn <= (mode == 1) || (mode == 2 && accepted < StreamCount && $urandom % 4 != 0);
            predStream <= randomStream();
            cacheReady <= (mode == 3) || (mode == 2 && readyLevel);
            redirect <= redir;
            commitCnt <= (`COMMIT_WIDTH)'(cnt);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            checkValue("predStall", 128'(predStall), 128'(tailCnt - headCnt == `FSQ_SIZE));
            checkValue("cacheReq.valid", 128'(cacheReq.valid), 128'(expReq.valid));
            if (expReq.valid) begin
                checkValue("cacheReq", 128'(cacheReq), 128'(expReq));
            end
            checkValue("update.valid", 128'(update.valid), 128'(expUpd.valid));
            if (expUpd.valid) begin
                checkValue("update", 128'(update), 128'(expUpd));
            end
            checkValue("squash.en", 128'(squash.en), 128'(lastRedirect.en));
            if (lastRedirect.en) begin
                checkValue("squash.target", 128'(squash.target), 128'(lastRedirect.target));
            end
        end
    end

    initial begin
        void'($urandom(63));
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        mode <= 1;
        // cache held off, so the queue fills and the ninth stream bounces
        while (tailCnt - headCnt < `FSQ_SIZE) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        mode <= 2;
        while (accepted < StreamCount) begin
            @(negedge clk);
        end
        // drain what is still queued
        mode <= 3;
        while (headCnt != tailCnt) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
